/* rtl/mctimer_pkg.sv */
//##########################################################################
// Multi-channel timer shared types
//##########################################################################

package mctimer_pkg;

    typedef logic [7:0]  addr_t;   // APB byte address
    typedef logic [31:0] data_t;   // APB data word

    // Master side of the bus
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    // Slave side, pready always high
    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // Channel config, CFG register bit 0 is enable, bit 1 is periodic
    typedef struct packed {
        logic enable;
        logic periodic;   // 0 = one-shot
    } chan_cfg_t;

    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,   // Count held at 0
        CH_RUN  = 2'd1,
        CH_DONE = 2'd2    // One-shot fired, waits for enable 0
    } chan_state_e;

    // Global registers
    localparam addr_t REG_STATUS = 8'h00;   // Sticky expiry, W1C
    localparam addr_t REG_IRQ_EN = 8'h04;

    // Channel blocks
    localparam addr_t CH_BASE    = 8'h10;
    localparam addr_t CH_STRIDE  = 8'h10;
    localparam addr_t CH_PERIOD  = 8'h0;
    localparam addr_t CH_CFG     = 8'h4;
    localparam addr_t CH_COUNT   = 8'h8;   // Read only

endpackage

/* rtl/mctimer_counter.sv */
//##########################################################################
// Timer channel counter
//##########################################################################

`timescale 1ns/1ps

module mctimer_counter #(
    parameter int CNT_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             count_en,
    input  logic             clear,    // Wins over count_en
    input  logic [CNT_W-1:0] period,
    output logic [CNT_W-1:0] count,
    output logic             expire    // One cycle after count hits period
);

    logic at_period;

    assign at_period = count == period;

    always_ff @(posedge clk) begin
        if (rst) begin
            count  <= '0;
            expire <= 1'b0;
        end else if (clear) begin
            count  <= '0;
            expire <= 1'b0;
        end else if (count_en) begin
            if (at_period) begin
                count  <= '0;      // Wrap, period+1 cycles per lap
                expire <= 1'b1;
            end else begin
                count  <= count + 1'b1;
                expire <= 1'b0;
            end
        end else begin
            expire <= 1'b0;        // Hold count
        end
    end

    // Back-to-back pulses only when every cycle is a full lap
    a_expire_single: assert property (@(posedge clk) disable iff (rst)
        expire |=> (!expire || period == '0));

endmodule

/* rtl/mctimer_chan_ctrl.sv */
//##########################################################################
// Timer channel control FSM
//##########################################################################

`timescale 1ns/1ps

module mctimer_chan_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  mctimer_pkg::chan_cfg_t cfg,
    input  logic                   expire,     // From the channel counter
    output logic                   count_en,
    output logic                   clear
);

    mctimer_pkg::chan_state_e state;
    mctimer_pkg::chan_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            mctimer_pkg::CH_IDLE: begin
                if (cfg.enable) state_nxt = mctimer_pkg::CH_RUN;
            end
            mctimer_pkg::CH_RUN: begin
                if (!cfg.enable) begin
                    state_nxt = mctimer_pkg::CH_IDLE;
                end else if (expire && !cfg.periodic) begin
                    state_nxt = mctimer_pkg::CH_DONE;   // One-shot fired
                end
            end
            mctimer_pkg::CH_DONE: begin
                // Re-arm needs enable to drop first
                if (!cfg.enable) state_nxt = mctimer_pkg::CH_IDLE;
            end
            default: state_nxt = mctimer_pkg::CH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mctimer_pkg::CH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign count_en = state == mctimer_pkg::CH_RUN;
    assign clear    = (state == mctimer_pkg::CH_IDLE) || (state == mctimer_pkg::CH_DONE);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {mctimer_pkg::CH_IDLE, mctimer_pkg::CH_RUN, mctimer_pkg::CH_DONE});

endmodule

/* rtl/mctimer_apb_regs.sv */
//##########################################################################
// Timer APB register block
//##########################################################################

`timescale 1ns/1ps

module mctimer_apb_regs #(
    parameter int NUM_CH = 4,
    parameter int CNT_W  = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mctimer_pkg::apb_req_t  apb_req,
    output mctimer_pkg::apb_rsp_t  apb_rsp,
    output mctimer_pkg::chan_cfg_t chan_cfg [NUM_CH],
    output logic [CNT_W-1:0]       period   [NUM_CH],
    input  logic [CNT_W-1:0]       count    [NUM_CH],
    input  logic [NUM_CH-1:0]      expire,   // One pulse per channel expiry
    output logic                   irq
);

    logic access;   // Access phase
    logic wr;
    logic in_ch_win;
    logic hit;      // Address is mapped
    mctimer_pkg::addr_t ch_off;
    mctimer_pkg::addr_t ch_idx;
    mctimer_pkg::addr_t reg_off;
    logic sel_status;
    logic sel_irq_en;
    logic [NUM_CH-1:0] sel_period;
    logic [NUM_CH-1:0] sel_cfg;
    logic [NUM_CH-1:0] sel_count;
    logic [NUM_CH-1:0] status;   // Sticky expiry flags
    logic [NUM_CH-1:0] irq_en;
    logic [NUM_CH-1:0] w1c;      // Clear mask from a status write
    mctimer_pkg::data_t rdata;

    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;

    // Split the address into channel number and register offset
    assign in_ch_win = apb_req.paddr >= mctimer_pkg::CH_BASE;
    assign ch_off    = apb_req.paddr - mctimer_pkg::CH_BASE;
    assign ch_idx    = ch_off / mctimer_pkg::CH_STRIDE;
    assign reg_off   = ch_off % mctimer_pkg::CH_STRIDE;

    assign sel_status = apb_req.paddr == mctimer_pkg::REG_STATUS;
    assign sel_irq_en = apb_req.paddr == mctimer_pkg::REG_IRQ_EN;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            sel_period[i] = in_ch_win && (ch_idx == mctimer_pkg::addr_t'(i))
                            && (reg_off == mctimer_pkg::CH_PERIOD);
            sel_cfg[i]    = in_ch_win && (ch_idx == mctimer_pkg::addr_t'(i))
                            && (reg_off == mctimer_pkg::CH_CFG);
            sel_count[i]  = in_ch_win && (ch_idx == mctimer_pkg::addr_t'(i))
                            && (reg_off == mctimer_pkg::CH_COUNT);
        end
    end

    assign hit = sel_status | sel_irq_en | (|sel_period) | (|sel_cfg) | (|sel_count);

    // Read mux, narrow fields zero-extended
    always_comb begin
        rdata = '0;
        if (sel_status) rdata = mctimer_pkg::data_t'(status);
        if (sel_irq_en) rdata = mctimer_pkg::data_t'(irq_en);
        for (int i = 0; i < NUM_CH; i++) begin
            if (sel_period[i]) rdata = mctimer_pkg::data_t'(period[i]);
            if (sel_cfg[i]) begin
                rdata    = '0;
                rdata[0] = chan_cfg[i].enable;
                rdata[1] = chan_cfg[i].periodic;
            end
            if (sel_count[i]) rdata = mctimer_pkg::data_t'(count[i]);
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;             // No wait states
    assign apb_rsp.pslverr = access & ~hit;    // Unmapped address

    assign w1c = (wr && sel_status) ? apb_req.pwdata[NUM_CH-1:0] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
            irq_en <= '0;
            irq    <= 1'b0;
            for (int i = 0; i < NUM_CH; i++) begin
                chan_cfg[i] <= '0;
                period[i]   <= '1;   // Max period out of reset
            end
        end else begin
            status <= (status & ~w1c) | expire;   // Set wins over clear
            irq    <= |(status & irq_en);
            if (wr && sel_irq_en) irq_en <= apb_req.pwdata[NUM_CH-1:0];
            for (int i = 0; i < NUM_CH; i++) begin
                if (wr && sel_period[i]) period[i] <= apb_req.pwdata[CNT_W-1:0];
                if (wr && sel_cfg[i]) begin
                    chan_cfg[i].enable   <= apb_req.pwdata[0];
                    chan_cfg[i].periodic <= apb_req.pwdata[1];
                end
                // COUNT writes dropped without error
            end
        end
    end

    // Every access phase completes in one cycle
    a_pready_high: assert property (@(posedge clk) disable iff (rst)
        access |-> apb_rsp.pready);

endmodule

/* rtl/mctimer_top.sv */
//##########################################################################
// Multi-channel timer top level
//##########################################################################

`timescale 1ns/1ps

module mctimer_top #(
    parameter int NUM_CH = 4,   // 1 to 8
    parameter int CNT_W  = 8    // 1 to 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mctimer_pkg::apb_req_t apb_req,
    output mctimer_pkg::apb_rsp_t apb_rsp,
    output logic [NUM_CH-1:0]     trig,
    output logic                  irq
);

    mctimer_pkg::chan_cfg_t chan_cfg [NUM_CH];
    logic [CNT_W-1:0]       period   [NUM_CH];
    logic [CNT_W-1:0]       count    [NUM_CH];
    logic [NUM_CH-1:0]      expire;

    mctimer_apb_regs #(
        .NUM_CH (NUM_CH),
        .CNT_W  (CNT_W)
    ) i_regs (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .chan_cfg (chan_cfg),
        .period   (period),
        .count    (count),
        .expire   (expire),
        .irq      (irq)
    );

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        logic count_en;
        logic clear;

        mctimer_chan_ctrl i_ctrl (
            .clk      (clk),
            .rst      (rst),
            .cfg      (chan_cfg[g]),
            .expire   (expire[g]),
            .count_en (count_en),
            .clear    (clear)
        );

        mctimer_counter #(
            .CNT_W (CNT_W)
        ) i_cnt (
            .clk      (clk),
            .rst      (rst),
            .count_en (count_en),
            .clear    (clear),
            .period   (period[g]),
            .count    (count[g]),
            .expire   (expire[g])
        );
    end

    assign trig = expire;   // Expiry pulses go straight out

endmodule

/* tb/mctimer_clkgen.sv */
//##########################################################################
// Testbench clock and reset
//##########################################################################

`timescale 1ns/1ps

module mctimer_clkgen #(
    parameter int PERIOD     = 4,    // ns
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* tb/mctimer_tb.sv */
//##########################################################################
// Multi-channel timer testbench
//##########################################################################

`timescale 1ns/1ps

module mctimer_tb;

    localparam int NUM_CH    = 4;
    localparam int CNT_W     = 8;
    localparam int NUM_TESTS = 6;

    // One row of the stimulus table
    typedef struct packed {
        logic [1:0]  ch;
        logic [7:0]  period;
        logic        periodic;   // 0 = one-shot
        logic [15:0] window;     // Cycles to count pulses
        logic [15:0] expected;   // Trigger pulses in the window
    } tbl_entry_t;

    logic                  clk;
    logic                  rst;
    mctimer_pkg::apb_req_t apb_req;
    mctimer_pkg::apb_rsp_t apb_rsp;
    logic [NUM_CH-1:0]     trig;
    logic                  irq;

    tbl_entry_t tbl      [NUM_TESTS];
    string      tbl_name [NUM_TESTS];
    int         trig_total [NUM_CH];     // Pulses seen per channel
    int         cycle_cnt;
    int         timeout_limit = 100000;  // Replaced once the table is built

    mctimer_clkgen #(.PERIOD(4), .RST_CYCLES(10)) i_clkgen (.clk(clk), .rst(rst));

    mctimer_top #(
        .NUM_CH (NUM_CH),
        .CNT_W  (CNT_W)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .trig    (trig),
        .irq     (irq)
    );

    // Trigger monitor sampled mid-cycle
    always @(negedge clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (rst) trig_total[c] = 0;
            else if (trig[c]) trig_total[c]++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Testbench failed");
            $fatal(1, "Timeout: run did not finish within %0d cycles", timeout_limit);
        end
    end

    task automatic check_value(input string name, input int exp, input int act, input int tol);
        if (act < exp - tol || act > exp + tol) begin
            $display("Error in %s: expected %0d, actual %0d", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic mctimer_pkg::addr_t ch_addr(input int ch, input mctimer_pkg::addr_t off);
        return mctimer_pkg::CH_BASE + mctimer_pkg::addr_t'(ch) * mctimer_pkg::CH_STRIDE + off;
    endfunction

    // One APB transfer of setup then access phase
    task automatic apb_xfer(input logic write, input mctimer_pkg::addr_t addr,
                            input mctimer_pkg::data_t wdata,
                            output mctimer_pkg::data_t rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #2;                       // Response settled before the edge
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value("apb pready", 1, int'(apb_rsp.pready), 0);   // No wait states
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic write_reg(input string name, input mctimer_pkg::addr_t addr,
                             input mctimer_pkg::data_t data);
        mctimer_pkg::data_t rdata;
        logic err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({name, " pslverr"}, 0, int'(err), 0);
    endtask

    task automatic expect_reg(input string name, input mctimer_pkg::addr_t addr, input int exp);
        mctimer_pkg::data_t rdata;
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value({name, " pslverr"}, 0, int'(err), 0);
        check_value(name, exp, int'(rdata), 0);
    endtask

    task automatic expect_slverr(input string name, input logic write,
                                 input mctimer_pkg::addr_t addr);
        mctimer_pkg::data_t rdata;
        logic err;
        apb_xfer(write, addr, 32'hffff_ffff, rdata, err);
        check_value(name, 1, int'(err), 0);
    endtask

    task automatic settle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Expected count follows the period+1 lap rule
    function automatic void add_entry(input int idx, input string name, input int ch,
                                      input logic periodic, input int window);
        int p;
        int exp_n;
        p = 3 + int'($urandom % 18);   // 3..20
        if (periodic) exp_n = window / (p + 1);
        else exp_n = (window > p + 1) ? 1 : 0;
        tbl_name[idx]     = name;
        tbl[idx].ch       = 2'(ch);
        tbl[idx].period   = 8'(p);
        tbl[idx].periodic = periodic;
        tbl[idx].window   = 16'(window);
        tbl[idx].expected = 16'(exp_n);
    endfunction

    task automatic run_entry(input int t);
        tbl_entry_t e;
        string name;
        int ch;
        int base;
        mctimer_pkg::data_t cfg_val;
        e       = tbl[t];
        name    = tbl_name[t];
        ch      = int'(e.ch);
        cfg_val = {30'd0, e.periodic, 1'b1};   // Bit 1 periodic, bit 0 enable
        write_reg(name, ch_addr(ch, mctimer_pkg::CH_PERIOD), mctimer_pkg::data_t'(e.period));
        base = trig_total[ch];
        write_reg(name, ch_addr(ch, mctimer_pkg::CH_CFG), cfg_val);
        settle(int'(e.window));
        if (e.periodic) begin
            check_value(name, int'(e.expected), trig_total[ch] - base, 1);  // Window edges
        end else begin
            check_value(name, int'(e.expected), trig_total[ch] - base, 0);
            expect_reg({name, " done count"}, ch_addr(ch, mctimer_pkg::CH_COUNT), 0);
            settle(int'(e.period) + 1);
            expect_reg({name, " done count"}, ch_addr(ch, mctimer_pkg::CH_COUNT), 0);
            // Re-arm through enable 0
            write_reg(name, ch_addr(ch, mctimer_pkg::CH_CFG), 0);
            base = trig_total[ch];
            write_reg(name, ch_addr(ch, mctimer_pkg::CH_CFG), cfg_val);
            settle(int'(e.window));
            check_value({name, " rearm"}, 1, trig_total[ch] - base, 0);
        end
        // Disabled channel stays quiet
        write_reg(name, ch_addr(ch, mctimer_pkg::CH_CFG), 0);
        settle(3);
        base = trig_total[ch];
        settle(2 * (int'(e.period) + 1));
        check_value({name, " disabled"}, 0, trig_total[ch] - base, 0);
        expect_reg({name, " disabled count"}, ch_addr(ch, mctimer_pkg::CH_COUNT), 0);
    endtask

    initial begin
        int mask;
        apb_req = '0;
        void'($urandom(32'hb7fb));
        add_entry(0, "periodic ch0", 0, 1'b1, 200);
        add_entry(1, "periodic ch1", 1, 1'b1, 150);
        add_entry(2, "oneshot ch2", 2, 1'b0, 60);
        add_entry(3, "periodic ch3", 3, 1'b1, 120);
        add_entry(4, "oneshot ch0", 0, 1'b0, 50);
        add_entry(5, "periodic ch2", 2, 1'b1, 100);
        timeout_limit = 2000;
        mask = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            timeout_limit += int'(tbl[t].window);
            if (tbl[t].expected != 0) mask |= 1 << tbl[t].ch;
        end

        wait (rst === 1'b1);
        wait (rst === 1'b0);
        settle(1);

        // Reset values
        check_value("reset trig", 0, int'(trig), 0);
        check_value("reset irq", 0, int'(irq), 0);
        expect_reg("reset status", mctimer_pkg::REG_STATUS, 0);
        expect_reg("reset irq_en", mctimer_pkg::REG_IRQ_EN, 0);
        for (int c = 0; c < NUM_CH; c++) begin
            expect_reg("reset cfg", ch_addr(c, mctimer_pkg::CH_CFG), 0);
            expect_reg("reset period", ch_addr(c, mctimer_pkg::CH_PERIOD), (1 << CNT_W) - 1);
        end

        // Register access
        write_reg("period rw", ch_addr(1, mctimer_pkg::CH_PERIOD), 32'h5a);
        expect_reg("period rw", ch_addr(1, mctimer_pkg::CH_PERIOD), 'h5a);
        write_reg("cfg rw", ch_addr(3, mctimer_pkg::CH_CFG), 32'h2);
        expect_reg("cfg rw", ch_addr(3, mctimer_pkg::CH_CFG), 2);
        write_reg("count ro", ch_addr(0, mctimer_pkg::CH_COUNT), 32'h33);
        expect_reg("count ro", ch_addr(0, mctimer_pkg::CH_COUNT), 0);
        expect_reg("count ro period", ch_addr(0, mctimer_pkg::CH_PERIOD), (1 << CNT_W) - 1);
        expect_slverr("unmapped 0x08", 1'b1, 8'h08);
        expect_slverr("unmapped 0x4c", 1'b1, 8'h4c);
        expect_slverr("unmapped 0x50", 1'b0, 8'h50);
        expect_slverr("unmapped 0xfc", 1'b1, 8'hfc);
        expect_reg("after unmapped cfg", ch_addr(3, mctimer_pkg::CH_CFG), 2);
        expect_reg("after unmapped irq_en", mctimer_pkg::REG_IRQ_EN, 0);
        expect_reg("after unmapped period", ch_addr(1, mctimer_pkg::CH_PERIOD), 'h5a);
        write_reg("cfg rw", ch_addr(3, mctimer_pkg::CH_CFG), 0);

        for (int t = 0; t < NUM_TESTS; t++) run_entry(t);

        // Sticky status and irq masking
        expect_reg("status sticky", mctimer_pkg::REG_STATUS, mask);
        check_value("irq masked", 0, int'(irq), 0);
        write_reg("irq_en ch2", mctimer_pkg::REG_IRQ_EN, 32'h4);
        settle(2);
        check_value("irq enabled", 1, int'(irq), 0);
        write_reg("status w1c ch2", mctimer_pkg::REG_STATUS, 32'h4);
        settle(2);
        check_value("irq after w1c", 0, int'(irq), 0);
        expect_reg("status after w1c", mctimer_pkg::REG_STATUS, mask & ~4);
        write_reg("irq_en others", mctimer_pkg::REG_IRQ_EN, 32'hb);
        settle(2);
        check_value("irq others", 1, int'(irq), 0);
        write_reg("status w1c all", mctimer_pkg::REG_STATUS, 32'hf);
        settle(2);
        check_value("irq cleared", 0, int'(irq), 0);
        expect_reg("status cleared", mctimer_pkg::REG_STATUS, 0);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* project.f */
rtl/mctimer_pkg.sv
rtl/mctimer_counter.sv
rtl/mctimer_chan_ctrl.sv
rtl/mctimer_apb_regs.sv
rtl/mctimer_top.sv
tb/mctimer_clkgen.sv
tb/mctimer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the timer testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module mctimer_tb \
    -o mctimer_sim \
    && ./obj_dir/mctimer_sim \
    || { echo "Simulation run failed"; exit 1; }
